// ==== design/n64_pkg.sv ====
package n64_pkg;

    typedef enum logic [1:0] {
        dev_sdram,
        dev_bootloader,
        dev_cfg,
        dev_ddregs
    } n64_dev_e;

    localparam int num_devs = 4;

    // upper address byte of each region.
    localparam logic [7:0] ddregs_base   = 8'h05;
    localparam logic [7:0] sdram_base_lo = 8'h10; // spans 10..13.
    localparam logic [7:0] cfg_base      = 8'h1E;
    localparam logic [7:0] boot_base     = 8'h1F;

    localparam int sdram_words = 1024;
    localparam int boot_words  = 32;

    localparam logic [15:0] cfg_version   = 16'h6401;
    localparam logic [15:0] ddregs_status = 16'h0040;

    typedef struct packed {
        logic        write;
        logic [31:0] address;
        logic [15:0] wdata;
    } n64_bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata; // only valid with ack.
    } n64_bus_rsp_t;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } pi_state_e;

endpackage

// ==== design/n64_pi.sv ====
`timescale 1ns/1ps

module n64_pi
    import n64_pkg::*;
(
    input  logic                        sys,
    input  logic                        arst_n,
    input  logic                        aleh,
    input  logic                        alel,
    input  logic                        read,
    input  logic                        write,
    input  logic [15:0]                 ad_in,
    output logic [15:0]                 ad_out,
    output logic                        ad_oe,
    output n64_bus_req_t                req,
    output logic [num_devs-1:0]         sel,
    input  n64_bus_rsp_t [num_devs-1:0] rsp
);

    pi_state_e           state;
    logic [31:0]         addr;
    logic [15:0]         wdata_q;
    logic                is_write;
    logic                read_q;
    logic                write_q;
    logic                read_fall;
    logic                write_fall;
    logic                mapped;
    n64_dev_e            dev;
    logic [num_devs-1:0] acks;
    logic                dev_ack;
    logic                done;

    assign read_fall  = read_q & ~read;
    assign write_fall = write_q & ~write;

    always_comb begin
        mapped = 1'b1;
        dev    = dev_sdram;
        if (addr[31:26] == sdram_base_lo[7:2]) begin
            dev = dev_sdram;
        end else if (addr[31:24] == boot_base) begin
            dev = dev_bootloader;
        end else if (addr[31:24] == cfg_base) begin
            dev = dev_cfg;
        end else if (addr[31:24] == ddregs_base) begin
            dev = dev_ddregs;
        end else begin
            mapped = 1'b0; // nothing mapped here so complete locally.
        end
    end

    always_comb begin
        for (int i = 0; i < num_devs; i++) begin
            acks[i] = rsp[i].ack;
        end
    end

    assign dev_ack = acks[dev];
    assign done    = (state == st_req && !mapped) || (state == st_wait && dev_ack);

    always_comb begin
        sel = '0;
        if (state == st_req && mapped) begin
            sel[dev] = 1'b1; // single-cycle request pulse.
        end
    end

    assign req = '{write: is_write, address: addr, wdata: wdata_q};

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            read_q   <= 1'b1;
            write_q  <= 1'b1;
            state    <= st_idle;
            addr     <= '0;
            is_write <= 1'b0;
            ad_oe    <= 1'b0;
        end else begin
            read_q  <= read;
            write_q <= write;
            if (aleh) addr[31:16] <= ad_in;
            if (alel) addr[15:0] <= ad_in;
            if (read) ad_oe <= 1'b0;
            case (state)
                st_idle: begin
                    if (read_fall || write_fall) begin
                        state    <= st_req;
                        is_write <= write_fall;
                    end
                end
                st_req: begin
                    state <= mapped ? st_wait : st_idle;
                end
                st_wait: begin
                    if (dev_ack) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
            if (done) begin
                addr <= addr + 32'd2; // next halfword.
                if (!is_write) ad_oe <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys) begin
        if (state == st_idle && write_fall) wdata_q <= ad_in;
        if (done && !is_write) begin
            ad_out <= mapped ? rsp[dev].rdata : 16'h0000;
        end
    end

    // request fields hold from the pulse until the ack.
    req_stable: assert property (@(posedge sys) disable iff (!arst_n)
        state == st_wait |-> $stable(req));

    // a device may only answer an access the controller is waiting on.
    no_stray_ack: assert property (@(posedge sys) disable iff (!arst_n)
        state == st_idle |-> acks == '0);

endmodule

// ==== design/n64_sdram.sv ====
`timescale 1ns/1ps

module n64_sdram
    import n64_pkg::*;
(
    input  logic         sys,
    input  logic         arst_n,
    input  logic         sdram_writable,
    input  logic         sel,
    input  n64_bus_req_t req,
    output n64_bus_rsp_t rsp
);

    logic [15:0] mem [sdram_words];
    logic [9:0]  idx_q;
    logic        p1;
    logic        ack_q;
    logic [15:0] rdata_q;

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            p1    <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            p1    <= sel; // cas stage.
            ack_q <= p1;
        end
    end

    always_ff @(posedge sys) begin
        if (sel) begin
            idx_q <= req.address[10:1];
            if (req.write && sdram_writable) begin
                mem[req.address[10:1]] <= req.wdata; // locked writes still ack.
            end
        end
        if (p1) rdata_q <= mem[idx_q];
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

    no_overlap: assert property (@(posedge sys) disable iff (!arst_n)
        sel |-> !(p1 || ack_q));

endmodule

// ==== design/n64_bootloader.sv ====
`timescale 1ns/1ps

module n64_bootloader
    import n64_pkg::*;
(
    input  logic         sys,
    input  logic         arst_n,
    input  logic         sel,
    input  n64_bus_req_t req,
    output n64_bus_rsp_t rsp
);

    logic [15:0] rom [boot_words];
    logic        ack_q;
    logic [15:0] rdata_q;

    initial $readmemh("design/boot.hex", rom);

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) ack_q <= 1'b0;
        else         ack_q <= sel; // writes acked, nothing stored.
    end

    always_ff @(posedge sys) begin
        if (sel) rdata_q <= rom[req.address[5:1]];
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

// ==== design/n64_cfg.sv ====
`timescale 1ns/1ps

module n64_cfg
    import n64_pkg::*;
(
    input  logic         sys,
    input  logic         arst_n,
    input  logic         sel,
    input  n64_bus_req_t req,
    output n64_bus_rsp_t rsp,
    output logic         sdram_writable
);

    logic [15:0] ctrl;
    logic [15:0] scratch1;
    logic [15:0] scratch3;
    logic        ack_q;
    logic [15:0] rdata_q;

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            ctrl     <= '0;
            scratch1 <= '0;
            scratch3 <= '0;
            ack_q    <= 1'b0;
            rdata_q  <= '0;
        end else begin
            ack_q <= sel;
            if (sel && req.write) begin
                case (req.address[2:1])
                    2'd0: ctrl <= req.wdata;
                    2'd1: scratch1 <= req.wdata;
                    2'd3: scratch3 <= req.wdata;
                    default: ; // version is read only.
                endcase
            end
            if (sel) begin
                case (req.address[2:1])
                    2'd0: rdata_q <= ctrl;
                    2'd1: rdata_q <= scratch1;
                    2'd2: rdata_q <= cfg_version;
                    default: rdata_q <= scratch3;
                endcase
            end
        end
    end

    assign rsp            = '{ack: ack_q, rdata: rdata_q};
    assign sdram_writable = ctrl[0];

endmodule

// ==== design/n64_dummy.sv ====
`timescale 1ns/1ps

module n64_dummy
    import n64_pkg::*;
(
    input  logic         sys,
    input  logic         arst_n,
    input  logic         sel,
    input  n64_bus_req_t req,
    output n64_bus_rsp_t rsp
);

    typedef enum logic {
        dd_idle,
        dd_wait
    } dd_state_e;

    dd_state_e state;
    logic      ack_q;

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            state <= dd_idle;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                dd_idle: begin
                    if (sel) begin
                        state <= dd_wait;
                        ack_q <= 1'b1;
                    end
                end
                default: state <= dd_idle;
            endcase
        end
    end

    always_comb begin
        rsp.ack   = ack_q;
        rsp.rdata = 16'h0000;
        if (ack_q && !req.address[1]) rsp.rdata = ddregs_status; // status at even pairs.
    end

endmodule

// ==== design/n64_soc.sv ====
`timescale 1ns/1ps

module n64_soc
    import n64_pkg::*;
(
    input  logic        sys,
    input  logic        arst_n,
    input  logic        aleh,
    input  logic        alel,
    input  logic        read,
    input  logic        write,
    input  logic [15:0] ad_in,
    output logic [15:0] ad_out,
    output logic        ad_oe
);

    n64_bus_req_t                req;
    logic [num_devs-1:0]         sel;
    n64_bus_rsp_t [num_devs-1:0] rsp;
    logic                        sdram_writable;

    n64_pi pi0 (
        .sys(sys),
        .arst_n(arst_n),
        .aleh(aleh),
        .alel(alel),
        .read(read),
        .write(write),
        .ad_in(ad_in),
        .ad_out(ad_out),
        .ad_oe(ad_oe),
        .req(req),
        .sel(sel),
        .rsp(rsp)
    );

    n64_sdram sdram0 (
        .sys(sys),
        .arst_n(arst_n),
        .sdram_writable(sdram_writable),
        .sel(sel[dev_sdram]),
        .req(req),
        .rsp(rsp[dev_sdram])
    );

    n64_bootloader boot0 (
        .sys(sys),
        .arst_n(arst_n),
        .sel(sel[dev_bootloader]),
        .req(req),
        .rsp(rsp[dev_bootloader])
    );

    n64_cfg cfg0 (
        .sys(sys),
        .arst_n(arst_n),
        .sel(sel[dev_cfg]),
        .req(req),
        .rsp(rsp[dev_cfg]),
        .sdram_writable(sdram_writable)
    );

    n64_dummy ddregs0 (
        .sys(sys),
        .arst_n(arst_n),
        .sel(sel[dev_ddregs]),
        .req(req),
        .rsp(rsp[dev_ddregs])
    );

endmodule

// ==== test/tb_n64_soc.sv ====
`timescale 1ns/1ps

module tb_n64_soc
    import n64_pkg::*;
();

    localparam int max_cycles = 4000; // about 300 strobes of 8 cycles plus latches and margin.

    logic        sys;
    logic        arst_n;
    logic        aleh;
    logic        alel;
    logic        read;
    logic        write;
    logic [15:0] ad_in;
    logic [15:0] ad_out;
    logic        ad_oe;

    integer      seed = 17814;
    int          mismatches = 0;
    int          failures = 0;
    int          cycles = 0;
    logic [31:0] cur_addr;
    string       cur_name;
    logic [15:0] cur_exp;
    logic [15:0] cur_got;
    event        sample_ev;

    logic [15:0] model_sdram [sdram_words];
    logic [15:0] model_boot [boot_words];
    logic [15:0] model_cfg [4];

    n64_soc dut0 (
        .sys(sys),
        .arst_n(arst_n),
        .aleh(aleh),
        .alel(alel),
        .read(read),
        .write(write),
        .ad_in(ad_in),
        .ad_out(ad_out),
        .ad_oe(ad_oe)
    );

    initial begin
        sys = 1'b0;
        forever #10 sys = ~sys;
    end

    always @(posedge sys) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %04h, actual %04h", name, expected, actual);
            mismatches++;
        end
    endtask

    always @(sample_ev) check(cur_name, cur_exp, cur_got);

    // 0 sdram, 1 boot, 2 cfg, 3 ddregs, -1 nothing there.
    function automatic int region(input logic [31:0] a);
        if (a[31:24] >= 8'h10 && a[31:24] <= 8'h13) return 0;
        if (a[31:24] == 8'h1F) return 1;
        if (a[31:24] == 8'h1E) return 2;
        if (a[31:24] == 8'h05) return 3;
        return -1;
    endfunction

    function automatic logic [15:0] expect_read(input logic [31:0] a);
        case (region(a))
            0: return model_sdram[a[10:1]];
            1: return model_boot[a[5:1]];
            2: return (a[2:1] == 2'd2) ? 16'h6401 : model_cfg[a[2:1]];
            3: return a[1] ? 16'h0000 : 16'h0040;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic void model_write(input logic [31:0] a, input logic [15:0] d);
        case (region(a))
            0: if (model_cfg[0][0]) model_sdram[a[10:1]] = d; // lock bit gates it.
            2: if (a[2:1] != 2'd2) model_cfg[a[2:1]] = d;
            default: ;
        endcase
    endfunction

    task automatic set_address(input logic [31:0] a);
        @(posedge sys);
        #1;
        aleh  = 1'b1;
        ad_in = a[31:16];
        @(posedge sys);
        #1;
        aleh  = 1'b0;
        alel  = 1'b1;
        ad_in = a[15:0];
        @(posedge sys);
        #1;
        alel     = 1'b0;
        cur_addr = a;
    endtask

    task automatic pi_read(input string name);
        logic [15:0] expected;
        expected = expect_read(cur_addr);
        cur_addr = cur_addr + 32'd2;
        @(posedge sys);
        #1;
        read = 1'b0;
        repeat (5) @(posedge sys);
        #1;
        if (ad_oe !== 1'b1) begin
            $display("Error: ad_oe was not driven during read strobe of %s", name);
            failures++;
        end
        cur_name = name;
        cur_exp  = expected;
        cur_got  = ad_out;
        -> sample_ev;
        @(posedge sys);
        #1;
        read = 1'b1;
        @(posedge sys);
        #1;
        if (ad_oe !== 1'b0) begin
            $display("Error: ad_oe still high after read strobe of %s ended", name);
            failures++;
        end
    endtask

    task automatic pi_write(input logic [15:0] data);
        @(posedge sys);
        #1;
        write = 1'b0;
        ad_in = data;
        model_write(cur_addr, data);
        cur_addr = cur_addr + 32'd2;
        repeat (6) @(posedge sys);
        #1;
        write = 1'b1;
        @(posedge sys);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] a;
        arst_n   = 1'b0;
        aleh     = 1'b0;
        alel     = 1'b0;
        read     = 1'b1;
        write    = 1'b1;
        ad_in    = '0;
        cur_addr = '0;
        foreach (model_sdram[k]) model_sdram[k] = '0;
        foreach (model_cfg[k]) model_cfg[k] = '0;
        $readmemh("design/boot.hex", model_boot);
        repeat (4) @(posedge sys);
        #1;
        arst_n = 1'b1;

        if (ad_oe !== 1'b0) begin
            $display("Error: ad_oe is high after reset with no strobe active");
            failures++;
        end
        set_address({cfg_base, 24'h0});
        repeat (4) pi_read("cfg_reset");

        set_address({sdram_base_lo, 24'h0}); // one latch for the whole burst.
        repeat (32) begin
            r = $random(seed);
            pi_write(r[15:0]);
        end
        set_address({sdram_base_lo, 24'h0});
        repeat (32) pi_read("sdram_locked");
        set_address({cfg_base, 24'h0});
        pi_write(16'h0001);
        set_address({sdram_base_lo, 24'h0});
        repeat (32) begin
            r = $random(seed);
            pi_write(r[15:0]);
        end
        set_address({sdram_base_lo, 24'h0});
        repeat (32) pi_read("sdram_open");

        set_address({boot_base, 24'h0});
        repeat (32) pi_read("boot_rom");
        set_address({boot_base, 24'h8});
        pi_write(16'hffff);
        set_address({boot_base, 24'h8});
        pi_read("boot_after_write");

        set_address({ddregs_base, 24'h0});
        repeat (8) pi_read("ddregs");
        set_address({ddregs_base, 24'h0});
        repeat (2) begin
            r = $random(seed);
            pi_write(r[15:0]);
        end
        set_address({ddregs_base, 24'h0});
        repeat (4) pi_read("ddregs_after_write");

        set_address(32'h2000_0000);
        repeat (4) pi_read("unmapped");
        set_address(32'h2000_0000);
        pi_write(16'ha5a5);
        pi_write(16'h5a5a);
        set_address({sdram_base_lo, 24'h0});
        repeat (2) pi_read("sdram_after_unmapped");
        set_address({cfg_base, 24'h0});
        repeat (4) pi_read("cfg_after_unmapped");

        for (int i = 0; i < 80; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            if (r[6:4] == 3'd0) begin
                set_address({cfg_base, 24'h0});
                pi_write({15'h0, r[7]}); // flip the sdram lock.
            end
            case (r[2:0])
                3'd1: a = {8'h1F, 18'h0, r2[5:1], 1'b0};
                3'd2: a = {8'h1E, 21'h0, r2[2:1], 1'b0};
                3'd3: a = {8'h05, 22'h0, r2[1], 1'b0};
                3'd4: a = {8'h20, r2[23:1], 1'b0};
                default: a = {6'b000100, r2[25:1], 1'b0};
            endcase
            set_address(a);
            if (r[8]) pi_write(r[31:16]);
            else pi_read("random_mix");
        end

        repeat (4) @(posedge sys);
        $display("Done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/n64_pkg.sv
design/n64_pi.sv
design/n64_sdram.sv
design/n64_bootloader.sv
design/n64_cfg.sv
design/n64_dummy.sv
design/n64_soc.sv
test/tb_n64_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_n64_soc
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --x-initial 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST) design/boot.hex
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "check: FAIL"; exit 1; \
	fi
	@echo "check: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/boot.hex ====
// one 16-bit bootloader word per line, word 0 first
3c1a
a430
8c08
2409
1100
0000
3c0b
a4f0
8d6c
258c
0d80
1520
ad4e
0004
3c1d
27bd
03e0
0008
4e36
4c1c
7b22
c019
6a9e
f145
0b71
5d38
e2c6
1fa4
96d3
2e8b
b750
08ff
